// ==== pace_subsys.f ====
+incdir+common
common/pace_data_pkg.sv
common/pace_cfg_pkg.sv
pace_table/pace_cfg_regs.sv
logic/pace_xmux.sv
logic/pace_bst_search.sv
logic/pace_horner.sv
logic/pace_top.sv
dv/pace_clk_gen.sv
dv/pace_props.sv
dv/pace_tb.sv

// ==== dv/pace_tb.sv ====
// Testbench of the piecewise polynomial approximation unit
// - reset, random, breakpoint-edge, bypass and coefficient reload tests
// - reference model of search, table routing and Horner evaluation
// - output comparison, watchdog and summary

`timescale 1ns/1ps

`include "pace_macros.svh"

module pace_tb
  import pace_data_pkg::*;
();

  localparam int H          = `PACE_H;
  localparam int W          = `PACE_W;
  localparam int CLK_NS     = 20;
  localparam int LATENCY    = 6;
  localparam int NUM_TESTS  = 5;
  localparam int NUM_VEC    = 1 + 200 + 2 + 24 + 24;
  localparam int NUM_CFG    = 32 + 24 + 25 + 25;
  localparam int BUDGET_CYC = NUM_VEC + NUM_CFG + NUM_TESTS * 40 + 100;

  typedef pace_word_t [H-1:0] vec_t;

  logic       clk;
  logic       arst_n;
  logic       cfg_we_i;
  logic [7:0] cfg_addr_i;
  pace_word_t cfg_wdata_i;
  logic       x_valid_i;
  vec_t       x_i;
  logic       y_valid_o;
  vec_t       y_o;

  pace_word_t tbl [H][W];  // Mirror of the DUT table
  logic       en_mirror;
  vec_t       exp_q [$];
  int         due_q [$];   // Cycle at which each vector must come out
  int         cyc;
  int         checks;
  int         errors;
  int         err_mark;
  int         prop_mark;
  integer     seed;
  pace_word_t bnd [7];     // Breakpoints in ascending order

  pace_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(3)) u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  pace_top dut_i (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .x_valid_i   (x_valid_i),
    .x_i         (x_i),
    .y_valid_o   (y_valid_o),
    .y_o         (y_o)
  );

  always @(posedge clk) cyc <= cyc + 1;

  function automatic pace_word_t pace_ref(input pace_word_t xv, input int lane);
    int                 node;
    int                 lvl;
    int                 row;
    pace_word_t         acc;
    logic signed [31:0] prod;
    node = 0;
    for (lvl = 0; lvl < 3; lvl++) begin
      node = (xv >= (en_mirror ? tbl[node][lvl] : tbl[lane][lvl])) ? 2 * node + 1 : 2 * node;
    end
    row = en_mirror ? node : lane;  // Bypassed crossbar reads the lane's own row
    acc = tbl[row][5];
    for (lvl = 1; lvl >= 0; lvl--) begin
      prod = acc * xv;
      acc  = prod[23:8] + tbl[row][3+lvl];
    end
    return acc;
  endfunction

  function automatic vec_t rnd_vec();
    vec_t v;
    for (int h = 0; h < H; h++) v[h] = pace_word_t'($random(seed));
    return v;
  endfunction

  task automatic check_val(input string name, input int lane, input pace_word_t exp,
                           input pace_word_t got);
    checks++;
    if (got !== exp) begin
      $display("** Error %s[%0d] exp %h got %h", name, lane, exp, got);
      errors++;
    end
  endtask

  task automatic note_failure(input string what);
    $display("Failure: %s", what);
    errors++;
  endtask

  task automatic drive_cfg(input logic [7:0] addr, input pace_word_t data);
    @(posedge clk);
    #2;
    x_valid_i   = 1'b0;
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
  endtask

  task automatic write_bp(input int lvl, input int node, input pace_word_t data);
    drive_cfg({2'b00, 3'(lvl), 3'(node)}, data);
    tbl[node][lvl] = data;
  endtask

  task automatic write_coef(input int deg, input int seg, input pace_word_t data);
    drive_cfg({2'b01, 3'(deg), 3'(seg)}, data);
    tbl[seg][3+deg] = data;
  endtask

  task automatic write_ctrl(input logic en);
    drive_cfg({2'b10, 6'd0}, {15'd0, en});
    en_mirror = en;
  endtask

  task automatic fill_coefs();
    for (int s = 0; s < H; s++) begin
      for (int d = 0; d < 3; d++) write_coef(d, s, pace_word_t'($random(seed)));
    end
  endtask

  task automatic drive_vec(input vec_t xv, input vec_t expv);
    @(posedge clk);
    #2;
    cfg_we_i  = 1'b0;
    x_valid_i = 1'b1;
    x_i       = xv;
    exp_q.push_back(expv);
    due_q.push_back(cyc + LATENCY);
  endtask

  task automatic send_vec(input vec_t xv);
    vec_t expv;
    for (int h = 0; h < H; h++) expv[h] = pace_ref(xv[h], h);
    drive_vec(xv, expv);
  endtask

  task automatic drain();
    @(posedge clk);
    #2;
    x_valid_i = 1'b0;
    cfg_we_i  = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (LATENCY) @(negedge clk);  // Room for a late or extra output
  endtask

  task automatic finish_test(input int num, input string name);
    drain();
    if (dut_i.u_props.fail_cnt != prop_mark) begin
      note_failure($sformatf("%0d bound assertions failed on output timing or reset",
                             dut_i.u_props.fail_cnt - prop_mark));
      prop_mark = dut_i.u_props.fail_cnt;
    end
    $display("Test %0d %s: %s (%0d errors)", num, name,
             (errors == err_mark) ? "ok" : "FAIL", errors - err_mark);
    err_mark = errors;
  endtask

  // Results are sampled on the falling edge, half a cycle after they settle
  always @(negedge clk) begin : compare_out
    vec_t expv;
    int   due;
    int   lane;
    if (arst_n && y_valid_o) begin
      if (exp_q.size() == 0) begin
        note_failure("y_valid_o pulsed with no vector in flight");
      end else begin
        expv = exp_q.pop_front();
        due  = due_q.pop_front();
        if (cyc != due) begin
          note_failure($sformatf("result came out at cycle %0d instead of %0d", cyc, due));
        end
        for (lane = 0; lane < H; lane++) check_val("y_o", lane, expv[lane], y_o[lane]);
      end
    end
  end

  initial begin : watchdog
    #(BUDGET_CYC * CLK_NS);
    $display("Watchdog expired after %0d cycles, the run did not complete", BUDGET_CYC);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    vec_t xv;
    vec_t expv;
    int   lane;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    x_valid_i   = 1'b0;
    x_i         = '0;
    seed        = 32'ha537;
    cyc         = 0;
    checks      = 0;
    errors      = 0;
    err_mark    = 0;
    prop_mark   = 0;
    en_mirror   = 1'b0;
    for (int r = 0; r < H; r++) begin
      for (int c = 0; c < W; c++) tbl[r][c] = '0;
    end
    bnd = '{16'hFD00, 16'hFE00, 16'hFF00, 16'h0000, 16'h0100, 16'h0200, 16'h0300};
    wait (arst_n === 1'b0);
    wait (arst_n === 1'b1);

    repeat (10) begin
      @(negedge clk);
      if (y_valid_o !== 1'b0) note_failure("y_valid_o left its low level with no input");
    end
    write_bp(0, 0, bnd[3]);  // Root splits the range in half
    write_bp(1, 0, bnd[1]);
    write_bp(1, 1, bnd[5]);
    for (int n = 0; n < 4; n++) write_bp(2, n, bnd[2*n]);
    fill_coefs();
    write_ctrl(1'b1);
    send_vec(rnd_vec());
    finish_test(1, "single vector after reset");

    repeat (200) send_vec(rnd_vec());
    finish_test(2, "random vectors back to back");

    // Constant polynomials make the output equal to the segment number
    for (int s = 0; s < H; s++) begin
      write_coef(2, s, '0);
      write_coef(1, s, '0);
      write_coef(0, s, pace_word_t'(s << 8));
    end
    for (lane = 0; lane < 7; lane++) begin
      xv[lane]   = bnd[lane];
      expv[lane] = pace_word_t'((lane + 1) << 8);
    end
    xv[H-1]   = 16'h8000;
    expv[H-1] = '0;
    drive_vec(xv, expv);
    for (lane = 0; lane < 7; lane++) begin
      xv[lane]   = bnd[lane] - 1;  // One LSB below stays in the lower segment
      expv[lane] = pace_word_t'(lane << 8);
    end
    xv[H-1]   = 16'h7FFF;
    expv[H-1] = 16'h0700;
    drive_vec(xv, expv);
    finish_test(3, "inputs on the breakpoints");

    fill_coefs();
    write_ctrl(1'b0);
    repeat (24) send_vec(rnd_vec());
    finish_test(4, "crossbar bypassed with enable cleared");

    write_ctrl(1'b1);
    repeat (8) send_vec(rnd_vec());
    drain();
    fill_coefs();
    repeat (16) send_vec(rnd_vec());
    finish_test(5, "coefficient reload while idle");

    $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/pace_props.sv ====
// Bound checks on the output side of the approximation unit
// - y_valid_o follows x_valid_i after the pipeline latency
// - y_o carries no unknown bits while valid
// - y_valid_o stays low during reset

`timescale 1ns/1ps

`include "pace_macros.svh"

module pace_props
  import pace_data_pkg::*;
#(
  localparam int unsigned LAT = 6
)(
  input logic                      clk_i,
  input logic                      arst_n_i,
  input logic                      x_valid_i,
  input logic                      y_valid_i,
  input pace_word_t [`PACE_H-1:0]  y_i
);

  logic [LAT-1:0] vld_sh;  // Input strobes still inside the pipeline
  int             fail_cnt = 0;  // Failed assertions so far

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_sh <= '0;
    end else begin
      vld_sh <= {vld_sh[LAT-2:0], x_valid_i};
    end
  end

  valid_latency_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    y_valid_i == vld_sh[LAT-1])
    else begin
      fail_cnt++;
      $error("y_valid_o out of step with x_valid_i");
    end

  known_data_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    y_valid_i |-> !$isunknown(y_i))
    else begin
      fail_cnt++;
      $error("y_o has unknown bits while valid");
    end

  reset_quiet_a: assert property (@(posedge clk_i)
    !arst_n_i |-> !y_valid_i)
    else begin
      fail_cnt++;
      $error("y_valid_o high during reset");
    end

endmodule

bind pace_top pace_props u_props (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .x_valid_i (x_valid_i),
  .y_valid_i (y_valid_o),
  .y_i       (y_o)
);

// ==== dv/pace_clk_gen.sv ====
// Clock and reset source of the testbench
// - free-running clock, 20 ns period
// - active-low reset held over the first rising edges

`timescale 1ns/1ps

module pace_clk_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 3
)(
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b1;
    #1;
    arst_n_o = 1'b0;  // Reset edge lands before the first clock edge
    repeat (RST_CYCLES) @(posedge clk_o);
    #2;
    arst_n_o = 1'b1;
  end

endmodule

// ==== logic/pace_top.sv ====
// Top level of the piecewise polynomial approximation unit
// - configuration registers feeding the table crossbar
// - breakpoint search followed by the Horner evaluator
// - assembly of the partition id matrix and split of the routed table

`timescale 1ns/1ps

`include "pace_macros.svh"

module pace_top
  import pace_data_pkg::*;
#(
  localparam int unsigned H     = `PACE_H,
  localparam int unsigned W     = `PACE_W,
  localparam int unsigned BP    = `PACE_PART_BST_STAGES,
  localparam int unsigned NPOLY = `PACE_NPOLY
)(
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               cfg_we_i,
  input  logic [7:0]         cfg_addr_i,
  input  pace_word_t         cfg_wdata_i,
  input  logic               x_valid_i,
  input  pace_word_t [H-1:0] x_i,
  output logic               y_valid_o,
  output pace_word_t [H-1:0] y_o
);

  pace_word_t [H-1:0][W-1:0]   table_w;
  pace_word_t [H-1:0][W-1:0]   routed_w;
  pace_pid_t  [H-1:0][W-1:0]   part_id_w;
  logic                        enable_w;
  pace_pid_t  [H-1:0][BP-1:0]  bst_pid_w;
  pace_word_t [H-1:0][BP-1:0]  bp_w;
  pace_pid_t  [H-1:0][NPOLY:0] hrn_pid_w;
  pace_word_t [H-1:0][NPOLY:0] coef_w;
  pace_pid_t  [H-1:0]          seg_w;
  pace_word_t [H-1:0]          x_dly_w;
  logic                        srch_valid_w;

  for (genvar h = 0; h < H; h++) begin : gen_lane
    for (genvar w = 0; w < BP; w++) begin : gen_bst_col
      assign part_id_w[h][w] = bst_pid_w[h][w];
      assign bp_w[h][w]      = routed_w[h][w];
    end
    for (genvar d = 0; d <= NPOLY; d++) begin : gen_coef_col
      assign part_id_w[h][BP+d] = hrn_pid_w[h][d];
      assign coef_w[h][d]       = routed_w[h][BP+d];
    end
    for (genvar w = BP + NPOLY + 1; w < W; w++) begin : gen_spare_col
      assign part_id_w[h][w] = '0;
    end
  end

  pace_cfg_regs u_cfg_regs (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .table_o     (table_w),
    .enable_o    (enable_w)
  );

  pace_xmux u_xmux (
    .x_input_i  (table_w),
    .enable_i   (enable_w),
    .part_id_i  (part_id_w),
    .x_output_o (routed_w)
  );

  pace_bst_search u_search (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .x_valid_i (x_valid_i),
    .x_i       (x_i),
    .bp_i      (bp_w),
    .part_id_o (bst_pid_w),
    .seg_o     (seg_w),
    .x_o       (x_dly_w),
    .valid_o   (srch_valid_w)
  );

  pace_horner u_horner (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .valid_i   (srch_valid_w),
    .x_i       (x_dly_w),
    .seg_i     (seg_w),
    .coef_i    (coef_w),
    .part_id_o (hrn_pid_w),
    .y_o       (y_o),
    .y_valid_o (y_valid_o)
  );

endmodule

// ==== logic/pace_horner.sv ====
// Pipelined Horner evaluator of the approximation unit
// A load stage takes the highest coefficient, then one multiply-add stage per
// lower degree computes acc * x >>> FRAC + c, wrapping to the word width

`timescale 1ns/1ps

`include "pace_macros.svh"

module pace_horner
  import pace_data_pkg::*;
#(
  localparam int unsigned H     = `PACE_H,
  localparam int unsigned BITW  = `PACE_BITW,
  localparam int unsigned FRAC  = `PACE_FRAC,
  localparam int unsigned NPOLY = `PACE_NPOLY,
  localparam int unsigned NST   = NPOLY + 1
)(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        valid_i,
  input  pace_word_t [H-1:0]          x_i,
  input  pace_pid_t  [H-1:0]          seg_i,
  input  pace_word_t [H-1:0][NPOLY:0] coef_i,
  output pace_pid_t  [H-1:0][NPOLY:0] part_id_o,
  output pace_word_t [H-1:0]          y_o,
  output logic                        y_valid_o
);

  pace_word_t [H-1:0] x_q   [NPOLY];  // The last stage no longer needs x or the segment
  pace_pid_t  [H-1:0] seg_q [NPOLY];
  pace_word_t [H-1:0] acc_q [NST];
  logic       [NST-1:0] vld_q;

  function automatic pace_word_t mac(pace_word_t acc, pace_word_t x, pace_word_t c);
    logic signed [2*BITW-1:0] prod;
    prod = acc * x;
    return pace_word_t'(prod >>> FRAC) + c;  // Back to Q8.8, the sum wraps
  endfunction

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[NST-2:0], valid_i};
    end
  end

  always_ff @(posedge clk_i) begin
    for (int h = 0; h < H; h++) begin
      acc_q[0][h] <= coef_i[h][NPOLY];
      x_q[0][h]   <= x_i[h];
      seg_q[0][h] <= seg_i[h];
      for (int k = 1; k < NST; k++) begin
        acc_q[k][h] <= mac(acc_q[k-1][h], x_q[k-1][h], coef_i[h][NPOLY-k]);
      end
      for (int k = 1; k < NPOLY; k++) begin
        x_q[k][h]   <= x_q[k-1][h];
        seg_q[k][h] <= seg_q[k-1][h];
      end
    end
  end

  // Stage k reads the degree NPOLY-k column with the segment it was handed
  always_comb begin
    for (int h = 0; h < H; h++) begin
      part_id_o[h][NPOLY] = seg_i[h];
      for (int k = 1; k < NST; k++) begin
        part_id_o[h][NPOLY-k] = seg_q[k-1][h];
      end
    end
  end

  assign y_o       = acc_q[NPOLY];
  assign y_valid_o = vld_q[NPOLY];

endmodule

// ==== logic/pace_bst_search.sv ====
// Pipelined breakpoint search of the approximation unit
// One register stage per tree level, each lane compares its x against the
// breakpoint of its current node and appends the result to its node index

`timescale 1ns/1ps

`include "pace_macros.svh"

module pace_bst_search
  import pace_data_pkg::*;
#(
  localparam int unsigned H = `PACE_H,
  localparam int unsigned S = `PACE_PART_BST_STAGES
)(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      x_valid_i,
  input  pace_word_t [H-1:0]        x_i,
  input  pace_word_t [H-1:0][S-1:0] bp_i,
  output pace_pid_t  [H-1:0][S-1:0] part_id_o,
  output pace_pid_t  [H-1:0]        seg_o,
  output pace_word_t [H-1:0]        x_o,
  output logic                      valid_o
);

  pace_word_t [H-1:0] x_q   [S];  // Lane data held by each stage
  pace_pid_t  [H-1:0] pid_q [S];  // Node index reached before this stage's level
  logic       [H-1:0] ge    [S];  // Upper branch taken at this stage's level
  logic       [S-1:0] vld_q;

  // Equal to the breakpoint takes the upper branch
  always_comb begin
    for (int s = 0; s < S; s++) begin
      for (int h = 0; h < H; h++) begin
        ge[s][h] = (x_q[s][h] >= bp_i[h][s]);
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[S-2:0], x_valid_i};
    end
  end

  always_ff @(posedge clk_i) begin
    x_q[0]   <= x_i;
    pid_q[0] <= '0;  // Every lane starts at the root
    for (int s = 1; s < S; s++) begin
      x_q[s] <= x_q[s-1];
      for (int h = 0; h < H; h++) begin
        pid_q[s][h] <= {pid_q[s-1][h][PIDW-2:0], ge[s-1][h]};
      end
    end
  end

  // Each stage steers its own breakpoint column, the last compare completes the segment
  always_comb begin
    for (int h = 0; h < H; h++) begin
      seg_o[h] = {pid_q[S-1][h][PIDW-2:0], ge[S-1][h]};
      for (int s = 0; s < S; s++) begin
        part_id_o[h][s] = pid_q[s][h];
      end
    end
  end

  assign x_o     = x_q[S-1];
  assign valid_o = vld_q[S-1];

endmodule

// ==== logic/pace_xmux.sv ====
// Table crossbar of the approximation unit
// - breakpoint columns select within the node group of their level
// - coefficient columns select across all rows
// - spare columns read as zero, and a disabled unit passes the table through

`timescale 1ns/1ps

`include "pace_macros.svh"

module pace_xmux
  import pace_data_pkg::*;
#(
  localparam int unsigned H     = `PACE_H,
  localparam int unsigned W     = `PACE_W,
  localparam int unsigned BP    = `PACE_PART_BST_STAGES,
  localparam int unsigned NPOLY = `PACE_NPOLY
)(
  input  pace_word_t [H-1:0][W-1:0] x_input_i,
  input  logic                      enable_i,
  input  pace_pid_t  [H-1:0][W-1:0] part_id_i,
  output pace_word_t [H-1:0][W-1:0] x_output_o
);

  pace_word_t [H-1:0][W-1:0] routed;

  for (genvar w = 0; w < W; w++) begin : gen_col
    localparam int GroupSize = 1 << w;
    if (w < BP) begin : gen_bst
      // The nodes of level w form one group in rows 0 to GroupSize-1
      if (GroupSize == 1) begin : gen_root
        for (genvar h = 0; h < H; h++) begin : gen_lane
          assign routed[h][w] = x_input_i[0][w];  // Single root node, no select needed
        end
      end else begin : gen_group
        pace_word_t grp [GroupSize];
        for (genvar g = 0; g < GroupSize; g++) begin : gen_entry
          assign grp[g] = x_input_i[g][w];
        end
        for (genvar h = 0; h < H; h++) begin : gen_lane
          assign routed[h][w] = grp[part_id_i[h][w][w-1:0]];  // Only w id bits are meaningful
        end
      end
    end else if (w <= BP + NPOLY) begin : gen_poly
      pace_word_t col [H];
      for (genvar g = 0; g < H; g++) begin : gen_entry
        assign col[g] = x_input_i[g][w];
      end
      for (genvar h = 0; h < H; h++) begin : gen_lane
        assign routed[h][w] = col[part_id_i[h][w]];  // Any lane may read any segment
      end
    end else begin : gen_spare
      for (genvar h = 0; h < H; h++) begin : gen_lane
        assign routed[h][w] = '0;
      end
    end
  end

  assign x_output_o = enable_i ? routed : x_input_i;

endmodule

// ==== pace_table/pace_cfg_regs.sv ====
// Configuration register block of the approximation unit
// - breakpoint and coefficient table, H rows by W columns
// - enable bit of the table crossbar
// Writes come from a one-cycle strobe with address and data

`timescale 1ns/1ps

`include "pace_macros.svh"

module pace_cfg_regs
  import pace_data_pkg::*;
  import pace_cfg_pkg::*;
#(
  localparam int unsigned H     = `PACE_H,
  localparam int unsigned W     = `PACE_W,
  localparam int unsigned BP    = `PACE_PART_BST_STAGES,
  localparam int unsigned NPOLY = `PACE_NPOLY,
  localparam int unsigned COLW  = $clog2(W)
)(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        cfg_we_i,
  input  pace_cfg_addr_u              cfg_addr_i,
  input  pace_word_t                  cfg_wdata_i,
  output pace_word_t [H-1:0][W-1:0]   table_o,
  output logic                        enable_o
);

  pace_word_t [H-1:0][W-1:0] table_q;
  logic                      enable_q;

  logic                      wr_en;
  pace_pid_t                 wr_row;
  logic [COLW-1:0]           wr_col;
  logic                      ctrl_we;

  // Address decode, the kind field picks the layout of the remaining bits
  always_comb begin
    wr_en   = 1'b0;
    wr_row  = '0;
    wr_col  = '0;
    ctrl_we = 1'b0;
    if (cfg_we_i) begin
      case (cfg_addr_i.bp.kind)
        CFG_KIND_BP: begin
          wr_row = cfg_addr_i.bp.node;
          wr_col = COLW'(cfg_addr_i.bp.level);
          // Level w only has 2**w nodes, anything beyond is dropped
          wr_en  = (cfg_addr_i.bp.level < BP) &&
                   ((cfg_addr_i.bp.node >> cfg_addr_i.bp.level) == '0);
        end
        CFG_KIND_COEF: begin
          wr_row = cfg_addr_i.coef.seg;
          wr_col = COLW'(BP) + COLW'(cfg_addr_i.coef.degree);  // Coefficients sit after breakpoints
          wr_en  = (cfg_addr_i.coef.degree <= NPOLY);
        end
        CFG_KIND_CTRL: begin
          ctrl_we = 1'b1;
        end
        default: begin
          wr_en = 1'b0;  // Reserved kind, write is ignored
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      table_q  <= '0;
      enable_q <= 1'b0;
    end else begin
      if (wr_en) begin
        table_q[wr_row][wr_col] <= cfg_wdata_i;
      end
      if (ctrl_we) begin
        enable_q <= cfg_wdata_i[0];
      end
    end
  end

  assign table_o  = table_q;
  assign enable_o = enable_q;

endmodule

// ==== common/pace_cfg_pkg.sv ====
// Configuration port types of the approximation unit
// - pace_cfg_kind_e, kind field at the top of every address
// - pace_bp_addr_t and pace_coef_addr_t, the two address layouts
// - pace_cfg_addr_u, one address word seen through either layout

package pace_cfg_pkg;

  typedef enum logic [1:0] {
    CFG_KIND_BP   = 2'd0,  // Breakpoint of one tree node
    CFG_KIND_COEF = 2'd1,  // Coefficient of one segment
    CFG_KIND_CTRL = 2'd2   // Control word, bit 0 is the enable
  } pace_cfg_kind_e;

  typedef struct packed {
    pace_cfg_kind_e kind;
    logic [2:0]     level;  // Tree level, also the breakpoint column
    logic [2:0]     node;   // Node index within that level
  } pace_bp_addr_t;

  typedef struct packed {
    pace_cfg_kind_e kind;
    logic [2:0]     degree;  // Power of x the coefficient multiplies
    logic [2:0]     seg;     // Segment, also the table row
  } pace_coef_addr_t;

  // Both views share the kind bits, so either one can be used to read the kind
  typedef union packed {
    pace_bp_addr_t   bp;
    pace_coef_addr_t coef;
  } pace_cfg_addr_u;

endpackage

// ==== common/pace_data_pkg.sv ====
// Datapath types of the approximation unit
// - pace_word_t, one signed fixed-point data word
// - pace_pid_t, partition id that steers the table crossbar

`include "pace_macros.svh"

package pace_data_pkg;

  // One bit of the partition id per tree level
  localparam int unsigned PIDW = `PACE_PART_BST_STAGES;

  typedef logic signed [`PACE_BITW-1:0] pace_word_t;

  // Node index within a level for breakpoint columns, segment for coefficient columns
  typedef logic [PIDW-1:0] pace_pid_t;

endpackage

// ==== common/pace_macros.svh ====
// Build-time dimensions of the piecewise polynomial approximation unit:
// lane count, word width, search depth, polynomial degree, table columns
// and the fixed-point fraction used by the multiply-add

`ifndef PACE_MACROS_SVH
`define PACE_MACROS_SVH

`define PACE_H               8   // Lanes, also rows (segments) of the table
`define PACE_BITW            16  // Signed Q8.8 data and coefficient width
`define PACE_PART_BST_STAGES 3   // Tree levels, segment count is 2 to this power
`define PACE_NPOLY           2   // Polynomial degree
`define PACE_W               6   // Breakpoint columns then coefficient columns
`define PACE_FRAC            8   // Fraction bits dropped after each product

`endif
